//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // ==================================================
  // widths and cache geometry
  // ==================================================
  localparam int XLEN          = 32;
  localparam int IC_LINE_BYTES = 8;
  localparam int IC_LINE_W     = IC_LINE_BYTES * 8;
  localparam int IC_LINES      = 8;
  localparam int IC_OFFSET_W   = $clog2(IC_LINE_BYTES);
  localparam int IC_INDEX_W    = $clog2(IC_LINES);
  localparam int IC_TAG_W      = XLEN - IC_INDEX_W - IC_OFFSET_W;

  localparam logic [XLEN-1:0] PC_RESET = 32'h8000_0000;

  typedef logic [XLEN-1:0]      vaddr_t;
  typedef logic [IC_LINE_W-1:0] ic_line_t;

  // fetch fsm encodings
  localparam int               FSM_W           = 3;
  localparam logic [FSM_W-1:0] INIT            = 3'd0;
  localparam logic [FSM_W-1:0] FETCH_REQ       = 3'd1;
  localparam logic [FSM_W-1:0] WAIT_IC_FILL    = 3'd2;
  localparam logic [FSM_W-1:0] WAIT_IBUF_FREE  = 3'd3;
  localparam logic [FSM_W-1:0] WAIT_FLUSH_FREE = 3'd4;

  // ==================================================
  // commit cause codes
  // ==================================================
  typedef enum logic [4:0] {
    SUPER_SOFT_INT       = 5'd1,
    MACHINE_SOFT_INT     = 5'd3,
    SUPER_TIMER_INT      = 5'd5,
    MACHINE_TIMER_INT    = 5'd7,
    SUPER_EXTERNAL_INT   = 5'd9,
    MACHINE_EXTERNAL_INT = 5'd11
  } int_code_e;

  typedef enum logic [4:0] {
    INST_ADDR_MISALIGN  = 5'd0,
    INST_ACC_FAULT      = 5'd1,
    ILLEGAL_INST        = 5'd2,
    BREAKPOINT          = 5'd3,
    LOAD_ADDR_MISALIGN  = 5'd4,
    LOAD_ACC_FAULT      = 5'd5,
    STAMO_ADDR_MISALIGN = 5'd6,
    STAMO_ACC_FAULT     = 5'd7,
    ECALL_U             = 5'd8,
    ECALL_S             = 5'd9,
    ECALL_M             = 5'd11,
    INST_PAGE_FAULT     = 5'd12,
    LOAD_PAGE_FAULT     = 5'd13,
    STAMO_PAGE_FAULT    = 5'd15,
    SILENT_FLUSH        = 5'd16,  // private codes from here on
    REPLAY_FLUSH        = 5'd17,
    MRET                = 5'd18,
    SRET                = 5'd19
  } exc_code_e;

  // irq view when the commit interrupt flag is set, exc view otherwise
  typedef union packed {
    int_code_e irq;
    exc_code_e exc;
  } commit_cause_u;

endpackage

`default_nettype wire

//--- design/redirect_target.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_target (
  input  logic                    i_commit_valid,
  input  logic                    i_commit_int,
  input  fetch_pkg::commit_cause_u i_commit_cause,
  input  fetch_pkg::vaddr_t       i_commit_epc,
  input  fetch_pkg::vaddr_t       i_csr_mtvec,
  input  fetch_pkg::vaddr_t       i_csr_stvec,
  input  fetch_pkg::vaddr_t       i_csr_mepc,
  input  fetch_pkg::vaddr_t       i_csr_sepc,
  input  logic [15:0]             i_csr_medeleg,
  input  logic                    i_br_mispredict,
  input  fetch_pkg::vaddr_t       i_br_target,
  output logic                    o_redirect_valid,
  output fetch_pkg::vaddr_t       o_redirect_addr
);

  logic [4:0]        w_code;          // raw cause bits
  fetch_pkg::vaddr_t w_mtvec_base;
  fetch_pkg::vaddr_t w_commit_target;

  assign w_code       = i_commit_cause;
  assign w_mtvec_base = {i_csr_mtvec[fetch_pkg::XLEN-1:1], 1'b0};

  always_comb begin
    w_commit_target = i_csr_mtvec;
    if (i_commit_int) begin
      case (i_commit_cause.irq)
        fetch_pkg::SUPER_SOFT_INT,
        fetch_pkg::MACHINE_SOFT_INT,
        fetch_pkg::SUPER_TIMER_INT,
        fetch_pkg::MACHINE_TIMER_INT,
        fetch_pkg::SUPER_EXTERNAL_INT,
        fetch_pkg::MACHINE_EXTERNAL_INT :
          w_commit_target = w_mtvec_base + (fetch_pkg::vaddr_t'(w_code) << 2);  // vectored
        default : w_commit_target = i_csr_mtvec;
      endcase
    end else begin
      case (i_commit_cause.exc)
        fetch_pkg::SILENT_FLUSH : w_commit_target = i_commit_epc + fetch_pkg::vaddr_t'(4);
        fetch_pkg::REPLAY_FLUSH : w_commit_target = i_commit_epc;
        fetch_pkg::MRET         : w_commit_target = i_csr_mepc;
        fetch_pkg::SRET         : w_commit_target = i_csr_sepc;
        // standard exceptions, trap base picked by delegation
        fetch_pkg::INST_ADDR_MISALIGN,
        fetch_pkg::INST_ACC_FAULT,
        fetch_pkg::ILLEGAL_INST,
        fetch_pkg::BREAKPOINT,
        fetch_pkg::LOAD_ADDR_MISALIGN,
        fetch_pkg::LOAD_ACC_FAULT,
        fetch_pkg::STAMO_ADDR_MISALIGN,
        fetch_pkg::STAMO_ACC_FAULT,
        fetch_pkg::ECALL_U,
        fetch_pkg::ECALL_S,
        fetch_pkg::ECALL_M,
        fetch_pkg::INST_PAGE_FAULT,
        fetch_pkg::LOAD_PAGE_FAULT,
        fetch_pkg::STAMO_PAGE_FAULT :
          w_commit_target = i_csr_medeleg[w_code[3:0]] ? i_csr_stvec : i_csr_mtvec;
        default : w_commit_target = i_csr_mtvec;
      endcase
    end
  end

  // commit beats a branch in the same cycle
  assign o_redirect_valid = i_commit_valid | i_br_mispredict;
  assign o_redirect_addr  = i_commit_valid  ? w_commit_target :
                            i_br_mispredict ? i_br_target     : '0;

endmodule

`default_nettype wire

//--- design/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_redirect_valid,
  input  fetch_pkg::vaddr_t i_redirect_addr,
  input  logic              i_ic_ready,
  input  logic              i_s2_miss,
  input  logic              i_s2_stall,
  input  fetch_pkg::vaddr_t i_s2_vaddr,
  output logic              o_s0_valid,
  output fetch_pkg::vaddr_t o_s0_vaddr,
  output logic              o_flush
);

  logic [fetch_pkg::FSM_W-1:0] r_state;
  logic [fetch_pkg::FSM_W-1:0] w_state_next;
  fetch_pkg::vaddr_t           r_s0_vaddr;       // address waiting to be issued
  fetch_pkg::vaddr_t           w_s0_vaddr_next;
  logic                        w_s0_valid;
  logic                        w_replay;

  // start of the line after the one holding addr
  function automatic fetch_pkg::vaddr_t next_line(input fetch_pkg::vaddr_t addr);
    fetch_pkg::vaddr_t base;
    base = {addr[fetch_pkg::XLEN-1:fetch_pkg::IC_OFFSET_W],
            {fetch_pkg::IC_OFFSET_W{1'b0}}};
    return base + fetch_pkg::vaddr_t'(fetch_pkg::IC_LINE_BYTES);
  endfunction

  assign w_replay = i_s2_miss | i_s2_stall;

  // ==================================================
  // next state and s0 address
  // ==================================================
  always_comb begin
    w_state_next    = r_state;
    w_s0_vaddr_next = r_s0_vaddr;
    w_s0_valid      = 1'b0;

    case (r_state)
      fetch_pkg::INIT : begin
        w_state_next = fetch_pkg::FETCH_REQ;
      end
      fetch_pkg::FETCH_REQ : begin
        if (w_replay) begin
          // s2 line lost, fetch it again from s0
          w_s0_vaddr_next = i_s2_vaddr;
          w_state_next    = i_s2_miss ? fetch_pkg::WAIT_IC_FILL : fetch_pkg::WAIT_IBUF_FREE;
        end else if (i_ic_ready) begin
          w_s0_valid      = 1'b1;
          w_s0_vaddr_next = next_line(r_s0_vaddr);
        end
      end
      fetch_pkg::WAIT_IC_FILL,
      fetch_pkg::WAIT_IBUF_FREE,
      fetch_pkg::WAIT_FLUSH_FREE : begin
        if (i_ic_ready) begin  // held address goes out
          w_s0_valid      = 1'b1;
          w_s0_vaddr_next = next_line(r_s0_vaddr);
          w_state_next    = fetch_pkg::FETCH_REQ;
        end
      end
      default : begin
        w_state_next = fetch_pkg::INIT;
      end
    endcase

    // redirect overrides everything above
    if (i_redirect_valid) begin
      if (r_state == fetch_pkg::INIT) begin
        w_s0_vaddr_next = i_redirect_addr;
      end else if (i_ic_ready) begin
        w_s0_valid      = 1'b1;
        w_s0_vaddr_next = next_line(i_redirect_addr);
        w_state_next    = fetch_pkg::FETCH_REQ;
      end else begin
        w_s0_vaddr_next = i_redirect_addr;  // park until the refill is done
        w_state_next    = fetch_pkg::WAIT_FLUSH_FREE;
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= fetch_pkg::INIT;
      r_s0_vaddr <= fetch_pkg::PC_RESET;
    end else begin
      r_state    <= w_state_next;
      r_s0_vaddr <= w_s0_vaddr_next;
    end
  end

  assign o_s0_valid = w_s0_valid;
  assign o_s0_vaddr = i_redirect_valid ? i_redirect_addr : r_s0_vaddr;
  assign o_flush    = i_redirect_valid | w_replay;  // kills s1 and s2

endmodule

`default_nettype wire

//--- design/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_fence_i,
  input  logic                i_s0_valid,
  input  fetch_pkg::vaddr_t   i_s0_vaddr,
  input  logic                i_s1_live,
  output logic                o_ready,
  output logic                o_s2_hit,
  output logic                o_s2_miss,
  output fetch_pkg::ic_line_t o_s2_data,
  output logic                o_mem_req_valid,
  output fetch_pkg::vaddr_t   o_mem_req_addr,
  input  logic                i_mem_req_ready,
  input  logic                i_mem_resp_valid,
  input  fetch_pkg::ic_line_t i_mem_resp_data
);

  // ==================================================
  // arrays
  // ==================================================
  logic [fetch_pkg::IC_TAG_W-1:0] tag_mem  [fetch_pkg::IC_LINES];
  fetch_pkg::ic_line_t            data_mem [fetch_pkg::IC_LINES];
  logic [fetch_pkg::IC_LINES-1:0] r_line_valid;

  logic [fetch_pkg::IC_TAG_W-1:0]   w_s0_tag;
  logic [fetch_pkg::IC_INDEX_W-1:0] w_s0_index;

  logic [fetch_pkg::IC_TAG_W-1:0]   r_s1_tag;       // tag of the s1 address
  logic [fetch_pkg::IC_INDEX_W-1:0] r_s1_index;
  logic [fetch_pkg::IC_TAG_W-1:0]   r_s1_tag_rd;    // stored tag
  logic                             r_s1_valid_rd;
  fetch_pkg::ic_line_t              r_s1_data;
  logic                             w_s1_hit;

  logic                r_s2_hit;
  logic                r_s2_miss;
  fetch_pkg::ic_line_t r_s2_data;

  logic                             r_busy;         // refill in progress
  logic                             r_req_valid;
  fetch_pkg::vaddr_t                r_req_addr;
  logic                             w_refill_start;
  logic                             w_refill_done;
  logic [fetch_pkg::IC_INDEX_W-1:0] w_refill_index;

  assign w_s0_tag   = i_s0_vaddr[fetch_pkg::XLEN-1 -: fetch_pkg::IC_TAG_W];
  assign w_s0_index = i_s0_vaddr[fetch_pkg::IC_OFFSET_W +: fetch_pkg::IC_INDEX_W];

  // s0 read
  always_ff @(posedge i_clk) begin
    if (i_s0_valid) begin
      r_s1_tag      <= w_s0_tag;
      r_s1_index    <= w_s0_index;
      r_s1_tag_rd   <= tag_mem[w_s0_index];
      r_s1_valid_rd <= r_line_valid[w_s0_index];
      r_s1_data     <= data_mem[w_s0_index];
    end
  end

  // s1 compare, result to s2
  assign w_s1_hit = r_s1_valid_rd & (r_s1_tag_rd == r_s1_tag);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s2_hit  <= 1'b0;
      r_s2_miss <= 1'b0;
    end else begin
      r_s2_hit  <= i_s1_live & w_s1_hit;
      r_s2_miss <= i_s1_live & ~w_s1_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s2_data <= r_s1_data;
  end

  // ==================================================
  // refill, one line outstanding
  // ==================================================
  assign w_refill_start = i_s1_live & ~w_s1_hit & ~r_busy;
  assign w_refill_done  = r_busy & ~r_req_valid & i_mem_resp_valid;
  assign w_refill_index = r_req_addr[fetch_pkg::IC_OFFSET_W +: fetch_pkg::IC_INDEX_W];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy      <= 1'b0;
      r_req_valid <= 1'b0;
    end else if (w_refill_start) begin
      r_busy      <= 1'b1;
      r_req_valid <= 1'b1;
    end else begin
      if (r_req_valid & i_mem_req_ready) begin
        r_req_valid <= 1'b0;  // accepted, wait for the response
      end
      if (w_refill_done) begin
        r_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_refill_start) begin
      r_req_addr <= {r_s1_tag, r_s1_index, {fetch_pkg::IC_OFFSET_W{1'b0}}};
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_line_valid <= '0;
    end else if (i_fence_i) begin
      r_line_valid <= '0;  // fence drops a refill landing in the same cycle
    end else if (w_refill_done) begin
      r_line_valid[w_refill_index] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_refill_done) begin
      tag_mem[w_refill_index]  <= r_req_addr[fetch_pkg::XLEN-1 -: fetch_pkg::IC_TAG_W];
      data_mem[w_refill_index] <= i_mem_resp_data;
    end
  end

  assign o_ready         = ~r_busy;
  assign o_s2_hit        = r_s2_hit;
  assign o_s2_miss       = r_s2_miss;
  assign o_s2_data       = r_s2_data;
  assign o_mem_req_valid = r_req_valid;
  assign o_mem_req_addr  = r_req_addr;

endmodule

`default_nettype wire

//--- design/fetch_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pipe (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_s0_valid,
  input  fetch_pkg::vaddr_t   i_s0_vaddr,
  input  logic                i_flush,
  input  logic                i_ic_hit,
  input  logic                i_ic_miss,
  input  fetch_pkg::ic_line_t i_ic_data,
  input  logic                i_ibuf_ready,
  output logic                o_s1_live,
  output logic                o_s2_miss,
  output logic                o_s2_stall,
  output fetch_pkg::vaddr_t   o_s2_vaddr,
  output logic                o_ibuf_valid,
  output fetch_pkg::vaddr_t   o_ibuf_pc,
  output fetch_pkg::ic_line_t o_ibuf_data
);

  logic              r_s1_valid;
  fetch_pkg::vaddr_t r_s1_vaddr;
  logic              r_s2_valid;
  fetch_pkg::vaddr_t r_s2_vaddr;
  logic              w_s1_live;
  logic              w_s2_load;    // live s2 hit offered to the buffer

  // a flush kills s1 before it moves on, s2 is overwritten
  assign w_s1_live = r_s1_valid & ~i_flush;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_valid;
      r_s2_valid <= w_s1_live;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr <= i_s0_vaddr;
    r_s2_vaddr <= r_s1_vaddr;
  end

  assign w_s2_load = r_s2_valid & i_ic_hit;

  assign o_s1_live    = w_s1_live;
  assign o_s2_miss    = r_s2_valid & i_ic_miss;
  assign o_s2_stall   = w_s2_load & ~i_ibuf_ready;  // not taken, will be refetched
  assign o_s2_vaddr   = r_s2_vaddr;
  assign o_ibuf_valid = w_s2_load;
  assign o_ibuf_pc    = r_s2_vaddr;
  assign o_ibuf_data  = i_ic_data;

endmodule

`default_nettype wire

//--- design/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  // commit and csr
  input  logic                     i_commit_valid,
  input  logic                     i_commit_int,
  input  fetch_pkg::commit_cause_u i_commit_cause,
  input  fetch_pkg::vaddr_t        i_commit_epc,
  input  fetch_pkg::vaddr_t        i_csr_mtvec,
  input  fetch_pkg::vaddr_t        i_csr_stvec,
  input  fetch_pkg::vaddr_t        i_csr_mepc,
  input  fetch_pkg::vaddr_t        i_csr_sepc,
  input  logic [15:0]              i_csr_medeleg,
  // branch
  input  logic                     i_br_mispredict,
  input  fetch_pkg::vaddr_t        i_br_target,
  input  logic                     i_fence_i,
  // memory port
  output logic                     o_mem_req_valid,
  output fetch_pkg::vaddr_t        o_mem_req_addr,
  input  logic                     i_mem_req_ready,
  input  logic                     i_mem_resp_valid,
  input  fetch_pkg::ic_line_t      i_mem_resp_data,
  // instruction buffer
  output logic                     o_ibuf_valid,
  output fetch_pkg::vaddr_t        o_ibuf_pc,
  output fetch_pkg::ic_line_t      o_ibuf_data,
  input  logic                     i_ibuf_ready
);

  logic                w_redirect_valid;
  fetch_pkg::vaddr_t   w_redirect_addr;
  logic                w_s0_valid;
  fetch_pkg::vaddr_t   w_s0_vaddr;
  logic                w_flush;
  logic                w_ic_ready;
  logic                w_ic_s2_hit;
  logic                w_ic_s2_miss;
  fetch_pkg::ic_line_t w_ic_s2_data;
  logic                w_s1_live;
  logic                w_s2_miss;      // gated by s2 valid
  logic                w_s2_stall;
  fetch_pkg::vaddr_t   w_s2_vaddr;

  redirect_target u_redirect_target (
    .i_commit_valid   (i_commit_valid),
    .i_commit_int     (i_commit_int),
    .i_commit_cause   (i_commit_cause),
    .i_commit_epc     (i_commit_epc),
    .i_csr_mtvec      (i_csr_mtvec),
    .i_csr_stvec      (i_csr_stvec),
    .i_csr_mepc       (i_csr_mepc),
    .i_csr_sepc       (i_csr_sepc),
    .i_csr_medeleg    (i_csr_medeleg),
    .i_br_mispredict  (i_br_mispredict),
    .i_br_target      (i_br_target),
    .o_redirect_valid (w_redirect_valid),
    .o_redirect_addr  (w_redirect_addr)
  );

  fetch_ctrl u_fetch_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_redirect_valid (w_redirect_valid),
    .i_redirect_addr  (w_redirect_addr),
    .i_ic_ready       (w_ic_ready),
    .i_s2_miss        (w_s2_miss),
    .i_s2_stall       (w_s2_stall),
    .i_s2_vaddr       (w_s2_vaddr),
    .o_s0_valid       (w_s0_valid),
    .o_s0_vaddr       (w_s0_vaddr),
    .o_flush          (w_flush)
  );

  icache u_icache (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_fence_i        (i_fence_i),
    .i_s0_valid       (w_s0_valid),
    .i_s0_vaddr       (w_s0_vaddr),
    .i_s1_live        (w_s1_live),
    .o_ready          (w_ic_ready),
    .o_s2_hit         (w_ic_s2_hit),
    .o_s2_miss        (w_ic_s2_miss),
    .o_s2_data        (w_ic_s2_data),
    .o_mem_req_valid  (o_mem_req_valid),
    .o_mem_req_addr   (o_mem_req_addr),
    .i_mem_req_ready  (i_mem_req_ready),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_data  (i_mem_resp_data)
  );

  fetch_pipe u_fetch_pipe (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_s0_valid       (w_s0_valid),
    .i_s0_vaddr       (w_s0_vaddr),
    .i_flush          (w_flush),
    .i_ic_hit         (w_ic_s2_hit),
    .i_ic_miss        (w_ic_s2_miss),
    .i_ic_data        (w_ic_s2_data),
    .i_ibuf_ready     (i_ibuf_ready),
    .o_s1_live        (w_s1_live),
    .o_s2_miss        (w_s2_miss),
    .o_s2_stall       (w_s2_stall),
    .o_s2_vaddr       (w_s2_vaddr),
    .o_ibuf_valid     (o_ibuf_valid),
    .o_ibuf_pc        (o_ibuf_pc),
    .o_ibuf_data      (o_ibuf_data)
  );

endmodule

`default_nettype wire

//--- verification/tb_imem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_imem_model #(
  parameter logic [31:0] SEED = 32'h4022
) (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  input  wire logic                i_req_valid,
  input  wire fetch_pkg::vaddr_t   i_req_addr,
  output logic                     o_req_ready,
  output logic                     o_resp_valid,
  output fetch_pkg::ic_line_t      o_resp_data
);

  int                req_count;     // bumped on each accepted request
  int                served_count;
  int                wait_cnt;
  fetch_pkg::vaddr_t pend_addr;
  logic [31:0]       rnd;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // line contents depend on every address bit
  function automatic fetch_pkg::ic_line_t line_data(input fetch_pkg::vaddr_t addr);
    return {addr ^ 32'h3c5a_96e1, ~addr + 32'h0101_0101};
  endfunction

  initial begin
    req_count = 0;
    pend_addr = '0;
  end

  always @(posedge i_clk) begin
    if (i_reset_n && i_req_valid && o_req_ready) begin
      req_count = req_count + 1;
      pend_addr = i_req_addr;
    end
  end

  // outputs change on the falling edge only
  initial begin
    o_req_ready  = 1'b0;
    o_resp_valid = 1'b0;
    o_resp_data  = '0;
    served_count = 0;
    rnd          = SEED;
    wait_cnt     = 2;
    forever begin
      @(negedge i_clk);
      rnd          = lcg_next(rnd);
      o_resp_valid = 1'b0;
      o_req_ready  = 1'b0;
      if (req_count != served_count) begin
        if (wait_cnt == 0) begin
          o_resp_valid = 1'b1;
          o_resp_data  = line_data(pend_addr);
          served_count = req_count;
          wait_cnt     = int'(rnd[18:16]);  // 0 to 7 extra cycles
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end else begin
        o_req_ready = rnd[21] | rnd[22];
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

  localparam logic [31:0] SEED   = 32'h4022;
  localparam int N_SEQ     = 24;
  localparam int N_RAND    = 120;
  localparam int N_CASES   = 9;
  localparam int N_FENCE   = 16;
  localparam int N_TOTAL   = N_SEQ + N_RAND + 4 * N_CASES + 2 * N_FENCE;
  localparam int WDOG_CYC  = N_TOTAL * 60 + 200;  // generous per-line budget

  localparam fetch_pkg::vaddr_t MTVEC = 32'h8000_1001;
  localparam fetch_pkg::vaddr_t STVEC = 32'h8000_2000;
  localparam fetch_pkg::vaddr_t MEPC  = 32'h8000_3004;
  localparam fetch_pkg::vaddr_t SEPC  = 32'h8000_4008;
  localparam logic [15:0]       DELEG = 16'h0100;   // ecall from U goes to S

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_commit_valid;
  logic                     i_commit_int;
  fetch_pkg::commit_cause_u i_commit_cause;
  fetch_pkg::vaddr_t        i_commit_epc;
  logic                     i_br_mispredict;
  fetch_pkg::vaddr_t        i_br_target;
  logic                     i_fence_i;
  logic                     i_ibuf_ready;
  logic                     mem_req_valid;
  fetch_pkg::vaddr_t        mem_req_addr;
  logic                     mem_req_ready;
  logic                     mem_resp_valid;
  fetch_pkg::ic_line_t      mem_resp_data;
  logic                     o_ibuf_valid;
  fetch_pkg::vaddr_t        o_ibuf_pc;
  fetch_pkg::ic_line_t      o_ibuf_data;

  int                errors;
  int                n_accept;
  int                n_req;
  int                fence_age;
  logic              fence_seen;
  logic              outstanding;
  logic              req_waiting;
  logic              found;
  logic              rand_ready;
  logic [31:0]       rnd;
  fetch_pkg::vaddr_t held_addr;
  fetch_pkg::vaddr_t exp_pc;
  fetch_pkg::vaddr_t exp_target;
  fetch_pkg::vaddr_t req_q[$];     // line requests since the last fence

  fetch_frontend dut0 (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_commit_valid (i_commit_valid), .i_commit_int (i_commit_int),
    .i_commit_cause (i_commit_cause), .i_commit_epc (i_commit_epc),
    .i_csr_mtvec (MTVEC), .i_csr_stvec (STVEC),
    .i_csr_mepc (MEPC), .i_csr_sepc (SEPC), .i_csr_medeleg (DELEG),
    .i_br_mispredict (i_br_mispredict), .i_br_target (i_br_target),
    .i_fence_i (i_fence_i),
    .o_mem_req_valid (mem_req_valid), .o_mem_req_addr (mem_req_addr),
    .i_mem_req_ready (mem_req_ready), .i_mem_resp_valid (mem_resp_valid),
    .i_mem_resp_data (mem_resp_data),
    .o_ibuf_valid (o_ibuf_valid), .o_ibuf_pc (o_ibuf_pc),
    .o_ibuf_data (o_ibuf_data), .i_ibuf_ready (i_ibuf_ready)
  );

  tb_imem_model #(.SEED (SEED)) mem0 (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_req_valid (mem_req_valid), .i_req_addr (mem_req_addr),
    .o_req_ready (mem_req_ready), .o_resp_valid (mem_resp_valid),
    .o_resp_data (mem_resp_data)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic fetch_pkg::vaddr_t line_of(input fetch_pkg::vaddr_t a);
    return a & ~32'h0000_0007;
  endfunction

  function automatic fetch_pkg::ic_line_t expect_line(input fetch_pkg::vaddr_t a);
    return {a ^ 32'h3c5a_96e1, ~a + 32'h0101_0101};
  endfunction

  // trap and return targets
  function automatic fetch_pkg::vaddr_t expect_target(input logic is_int,
      input logic [4:0] code, input fetch_pkg::vaddr_t epc);
    if (is_int) begin
      return {MTVEC[31:1], 1'b0} + {25'd0, code, 2'b00};
    end
    case (code)
      5'd16:   return epc + 32'd4;
      5'd17:   return epc;
      5'd18:   return MEPC;
      5'd19:   return SEPC;
      default: return (code < 5'd16 && DELEG[code[3:0]]) ? STVEC : MTVEC;
    endcase
  endfunction

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // ibuf ready pattern
  initial begin
    i_ibuf_ready = 1'b0;
    rnd          = SEED;
    forever begin
      @(negedge i_clk);
      rnd          = lcg_next(rnd);
      i_ibuf_ready = rand_ready ? (rnd[24:23] != 2'b00) : 1'b1;
    end
  end

  // ==================================================
  // reference pc tracking and checks
  // ==================================================
  always @(posedge i_clk) begin
    if (i_reset_n) begin
      if (o_ibuf_valid && i_ibuf_ready) begin
        n_accept = n_accept + 1;
        assert (o_ibuf_pc == exp_pc) else begin
          errors = errors + 1;
          $display("ERR o_ibuf_pc exp %h got %h", exp_pc, o_ibuf_pc);
        end
        assert (o_ibuf_data == expect_line(line_of(o_ibuf_pc))) else begin
          errors = errors + 1;
          $display("ERR o_ibuf_data pc %h exp %h got %h", o_ibuf_pc,
                   expect_line(line_of(o_ibuf_pc)), o_ibuf_data);
        end
        if (fence_seen && fence_age >= 2) begin
          found = 1'b0;
          foreach (req_q[k]) begin
            if (req_q[k] == line_of(o_ibuf_pc)) found = 1'b1;
          end
          assert (found) else begin
            errors = errors + 1;
            $display("line %h delivered after fence without a new memory request",
                     line_of(o_ibuf_pc));
          end
        end
        exp_pc = line_of(exp_pc) + 32'd8;
      end
      if (i_commit_valid || i_br_mispredict) exp_pc = exp_target;

      // memory port
      if (req_waiting) begin
        assert (mem_req_valid && mem_req_addr == held_addr) else begin
          errors = errors + 1;
          $display("ERR o_mem_req_valid %h o_mem_req_addr exp %h got %h",
                   mem_req_valid, held_addr, mem_req_addr);
        end
      end
      assert (!(mem_req_valid && outstanding)) else begin
        errors = errors + 1;
        $display("second memory request started before the response");
      end
      assert (!mem_req_valid || mem_req_addr[2:0] == 3'd0) else begin
        errors = errors + 1;
        $display("ERR o_mem_req_addr not line aligned %h", mem_req_addr);
      end
      if (mem_resp_valid) outstanding = 1'b0;
      if (mem_req_valid && mem_req_ready) begin
        outstanding = 1'b1;
        n_req       = n_req + 1;
        req_q.push_back(mem_req_addr);
      end
      req_waiting = mem_req_valid & ~mem_req_ready;
      held_addr   = mem_req_addr;

      fence_age = fence_age + 1;
      if (i_fence_i) begin
        req_q.delete();
        fence_seen = 1'b1;
        fence_age  = 0;
      end
    end
  end

  task automatic wait_accepts(input int n);
    int goal;
    goal = n_accept + n;
    while (n_accept < goal) @(negedge i_clk);
  endtask

  task automatic random_gap();
    repeat (int'(rnd[19:16])) @(negedge i_clk);
  endtask

  task automatic send_branch(input fetch_pkg::vaddr_t tgt);
    random_gap();
    i_br_mispredict = 1'b1;
    i_br_target     = tgt;
    exp_target      = tgt;
    @(negedge i_clk);
    i_br_mispredict = 1'b0;
    wait_accepts(3);
  endtask

  task automatic send_commit(input logic is_int, input fetch_pkg::commit_cause_u cause,
      input fetch_pkg::vaddr_t epc, input logic with_branch);
    random_gap();
    i_commit_valid  = 1'b1;
    i_commit_int    = is_int;
    i_commit_cause  = cause;
    i_commit_epc    = epc;
    i_br_mispredict = with_branch;
    i_br_target     = 32'h8000_0f00;
    exp_target      = expect_target(is_int, cause, epc);
    @(negedge i_clk);
    i_commit_valid  = 1'b0;
    i_br_mispredict = 1'b0;
    wait_accepts(3);
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    fetch_pkg::commit_cause_u c;
    i_reset_n       = 1'b0;
    i_commit_valid  = 1'b0;
    i_commit_int    = 1'b0;
    i_commit_cause  = '0;
    i_commit_epc    = '0;
    i_br_mispredict = 1'b0;
    i_br_target     = '0;
    i_fence_i       = 1'b0;
    rand_ready      = 1'b0;
    errors          = 0;
    n_accept        = 0;
    n_req           = 0;
    fence_age       = 0;
    fence_seen  = 1'b0;
    outstanding = 1'b0;
    req_waiting = 1'b0;
    held_addr   = '0;
    exp_target  = '0;
    exp_pc      = fetch_pkg::PC_RESET;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    assert (!o_ibuf_valid && !mem_req_valid) else begin
      errors = errors + 1;
      $display("ERR reset o_ibuf_valid %h o_mem_req_valid %h", o_ibuf_valid, mem_req_valid);
    end
    i_reset_n = 1'b1;

    wait_accepts(N_SEQ);          // straight line, ready always high
    rand_ready = 1'b1;
    wait_accepts(N_RAND);

    send_branch(32'h8000_0440);
    c.exc = fetch_pkg::SILENT_FLUSH;
    send_commit(1'b0, c, 32'h8000_0a0c, 1'b0);
    c.exc = fetch_pkg::REPLAY_FLUSH;
    send_commit(1'b0, c, 32'h8000_0b04, 1'b0);
    c.exc = fetch_pkg::MRET;
    send_commit(1'b0, c, 32'h8000_0000, 1'b0);
    c.exc = fetch_pkg::SRET;
    send_commit(1'b0, c, 32'h8000_0000, 1'b0);
    c.exc = fetch_pkg::ECALL_U;
    send_commit(1'b0, c, 32'h8000_0100, 1'b0);
    c.exc = fetch_pkg::ILLEGAL_INST;
    send_commit(1'b0, c, 32'h8000_0100, 1'b0);
    c.irq = fetch_pkg::MACHINE_TIMER_INT;
    send_commit(1'b1, c, 32'h8000_0200, 1'b0);
    c.exc = fetch_pkg::REPLAY_FLUSH;
    send_commit(1'b0, c, 32'h8000_0c00, 1'b1);

    // walk from the start, fence, then step back onto two lines still cached
    send_branch(fetch_pkg::PC_RESET);
    wait_accepts(N_FENCE);
    while (outstanding || mem_req_valid) @(negedge i_clk);
    i_fence_i = 1'b1;
    @(negedge i_clk);
    i_fence_i = 1'b0;
    send_branch(line_of(exp_pc) - 32'd16);
    wait_accepts(N_FENCE);

    repeat (4) @(negedge i_clk);
    $display("errors=%0d accepted=%0d mem_requests=%0d", errors, n_accept, n_req);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge i_clk);
    $display("timeout after %0d cycles, only %0d lines accepted", WDOG_CYC, n_accept);
    $display("errors=%0d accepted=%0d mem_requests=%0d", errors, n_accept, n_req);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
design/fetch_pkg.sv
design/redirect_target.sv
design/fetch_ctrl.sv
design/icache.sv
design/fetch_pipe.sv
design/fetch_frontend.sv
verification/tb_imem_model.sv
verification/tb_fetch_frontend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
